// ==== bridge_proto_pkg.sv ====
package bridge_proto_pkg;

    // Start of a host-to-device frame
    localparam logic [7:0] SOF_H2D = 8'hA5;

    // Result status codes
    localparam logic [7:0] STATUS_OK      = 8'h00;
    localparam logic [7:0] STATUS_CRC_ERR = 8'h01;
    localparam logic [7:0] STATUS_CMD_INV = 8'h02;
    localparam logic [7:0] STATUS_TIMEOUT = 8'h04;

    // Size field value with no defined transfer width
    localparam logic [1:0] SIZE_INVALID = 2'd3;

    // CRC-8, x^8 + x^2 + x + 1, MSB first, init 00h
    localparam logic [7:0] CRC_POLY = 8'h07;

    // 16 beats of 4 bytes at most
    localparam int MAX_PAYLOAD = 64;

    // Command byte layout
    typedef struct packed {
        logic       rw;    // 1 = read, no payload follows
        logic       inc;   // Address increment
        logic [1:0] size;  // 0 byte, 1 half-word, 2 word
        logic [3:0] len;   // Beat count minus one
    } cmd_fields_t;

endpackage

// ==== parser_pkg.sv ====
package parser_pkg;

    // Width of a payload index and of the byte count
    localparam int PAY_IDX_W = 6;

    typedef enum logic [3:0] {
        IDLE,
        CMD,
        ADDR0,
        ADDR1,
        ADDR2,
        ADDR3,
        DATA,
        CRC,
        DONE,
        ERROR
    } parser_state_t;

    // Captured frame header, address is little endian on the wire
    typedef struct packed {
        bridge_proto_pkg::cmd_fields_t cmd;
        logic [31:0]                   addr;
    } frame_hdr_t;

    // Outcome of a finished frame
    typedef struct packed {
        logic       valid;
        logic       error;
        logic [7:0] status;
    } frame_result_t;

endpackage

// ==== crc8_calc.sv ====
`timescale 1ns/1ps

module crc8_calc (
    input  logic       clk,
    input  logic       rst,
    input  logic       clear,
    input  logic       enable,
    input  logic [7:0] data_in,
    output logic [7:0] crc
);

    logic [7:0] crc_next;

    // Eight serial steps of the shift register unrolled into one cycle
    always_comb begin
        crc_next = crc ^ data_in;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[7]) begin
                crc_next = (crc_next << 1) ^ bridge_proto_pkg::CRC_POLY;
            end else begin
                crc_next = crc_next << 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            crc <= 8'h00;  // Initial value
        end else if (enable) begin
            crc <= crc_next;
        end
    end

endmodule

// ==== byte_timeout.sv ====
`timescale 1ns/1ps

module byte_timeout #(
    parameter int TIMEOUT_CYCLES = 0
) (
    input  logic clk,
    input  logic rst,
    input  logic frame_open,
    input  logic byte_seen,
    output logic timeout
);

    generate
        if (TIMEOUT_CYCLES == 0) begin : g_off
            assign timeout = 1'b0;  // Timeout disabled
        end else begin : g_on
            localparam int CW = $clog2(TIMEOUT_CYCLES + 1);
            localparam logic [CW-1:0] LIMIT = CW'(TIMEOUT_CYCLES);

            logic [CW-1:0] idle_cnt;

            // Counts empty cycles since the last byte of an open frame
            always_ff @(posedge clk) begin
                if (rst || !frame_open || byte_seen) begin
                    idle_cnt <= '0;
                    timeout  <= 1'b0;
                end else if (idle_cnt == LIMIT) begin
                    timeout <= 1'b1;  // One gap cycle past the limit
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    endgenerate

endmodule

// ==== payload_buffer.sv ====
`timescale 1ns/1ps

module payload_buffer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            clear,
    input  logic                            wr,
    input  logic [7:0]                      wr_byte,
    output logic [parser_pkg::PAY_IDX_W-1:0] count,
    input  logic [parser_pkg::PAY_IDX_W-1:0] rd_idx,
    output logic [7:0]                      rd_byte
);

    localparam int DEPTH = 2 ** parser_pkg::PAY_IDX_W;

    logic [7:0]                       mem [0:DEPTH-1];
    logic [parser_pkg::PAY_IDX_W-1:0] wr_ptr;

    // Write pointer doubles as the number of stored bytes
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            wr_ptr <= '0;
        end else if (wr) begin
            wr_ptr <= wr_ptr + 1'b1;  // Wraps to 0 after a full 64-byte payload
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= wr_byte;
        end
    end

    assign count = wr_ptr;

    // Combinational read for the consumer
    assign rd_byte = mem[rd_idx];

endmodule

// ==== frame_fsm.sv ====
`timescale 1ns/1ps

module frame_fsm (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [7:0]                       rx_fifo_data,
    input  logic                             rx_fifo_empty,
    output logic                             rx_fifo_rd_en,
    input  logic [7:0]                       crc,
    output logic                             crc_clear,
    output logic                             crc_enable,
    input  logic                             timeout,
    output logic                             frame_open,
    input  logic [parser_pkg::PAY_IDX_W-1:0] pay_count,
    output logic                             pay_clear,
    output logic                             pay_wr,
    input  logic                             frame_consumed,
    output parser_pkg::frame_hdr_t           hdr,
    output parser_pkg::frame_result_t        result,
    output logic                             busy
);

    // Wide enough to hold a full MAX_PAYLOAD byte count
    localparam int LEN_W = $clog2(bridge_proto_pkg::MAX_PAYLOAD + 1);

    parser_pkg::parser_state_t     state;
    parser_pkg::parser_state_t     state_next;
    parser_pkg::frame_result_t     result_next;
    bridge_proto_pkg::cmd_fields_t cmd_in;
    logic [LEN_W-1:0]              exp_len_in;
    logic [LEN_W-1:0]              exp_len;
    logic                          last_data;

    assign cmd_in = bridge_proto_pkg::cmd_fields_t'(rx_fifo_data);

    // Payload length of the incoming command byte
    always_comb begin
        if (cmd_in.rw || cmd_in.size == bridge_proto_pkg::SIZE_INVALID) begin
            exp_len_in = '0;
        end else begin
            exp_len_in = (LEN_W'(cmd_in.len) + LEN_W'(1)) << cmd_in.size;
        end
    end

    assign last_data = (LEN_W'(pay_count) + LEN_W'(1)) == exp_len;

    always_comb begin
        state_next    = state;
        result_next   = result;
        rx_fifo_rd_en = 1'b0;
        crc_clear     = 1'b0;
        crc_enable    = 1'b0;
        pay_clear     = 1'b0;
        pay_wr        = 1'b0;

        case (state)
            parser_pkg::IDLE: begin
                if (!rx_fifo_empty) begin
                    rx_fifo_rd_en = 1'b1;  // Anything but a start byte is dropped
                    if (rx_fifo_data == bridge_proto_pkg::SOF_H2D) begin
                        crc_clear  = 1'b1;
                        pay_clear  = 1'b1;
                        state_next = parser_pkg::CMD;
                    end
                end
            end

            parser_pkg::CMD, parser_pkg::ADDR0, parser_pkg::ADDR1, parser_pkg::ADDR2,
            parser_pkg::ADDR3, parser_pkg::DATA, parser_pkg::CRC: begin
                if (timeout) begin
                    // A stalled frame is dead even if a byte turns up now
                    state_next  = parser_pkg::ERROR;
                    result_next = '{valid: 1'b0, error: 1'b1,
                                    status: bridge_proto_pkg::STATUS_TIMEOUT};
                end else if (!rx_fifo_empty) begin
                    rx_fifo_rd_en = 1'b1;
                    crc_enable    = (state != parser_pkg::CRC);  // CRC byte itself not covered
                    pay_wr        = (state == parser_pkg::DATA);
                    case (state)
                        parser_pkg::CMD:   state_next = parser_pkg::ADDR0;
                        parser_pkg::ADDR0: state_next = parser_pkg::ADDR1;
                        parser_pkg::ADDR1: state_next = parser_pkg::ADDR2;
                        parser_pkg::ADDR2: state_next = parser_pkg::ADDR3;
                        parser_pkg::ADDR3: begin
                            state_next = (exp_len == '0) ? parser_pkg::CRC : parser_pkg::DATA;
                        end
                        parser_pkg::DATA: begin
                            if (last_data) begin
                                state_next = parser_pkg::CRC;
                            end
                        end
                        default: begin
                            // CRC byte, an invalid command outranks a CRC mismatch
                            state_next = parser_pkg::DONE;
                            if (hdr.cmd.size == bridge_proto_pkg::SIZE_INVALID) begin
                                result_next = '{valid: 1'b0, error: 1'b1,
                                                status: bridge_proto_pkg::STATUS_CMD_INV};
                            end else if (rx_fifo_data != crc) begin
                                result_next = '{valid: 1'b0, error: 1'b1,
                                                status: bridge_proto_pkg::STATUS_CRC_ERR};
                            end else begin
                                result_next = '{valid: 1'b1, error: 1'b0,
                                                status: bridge_proto_pkg::STATUS_OK};
                            end
                        end
                    endcase
                end
            end

            default: begin
                // DONE or ERROR, result held and FIFO left alone
                if (frame_consumed) begin
                    state_next  = parser_pkg::IDLE;
                    result_next = '0;
                    pay_clear   = 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= parser_pkg::IDLE;
            result <= '0;
        end else begin
            state  <= state_next;
            result <= result_next;
        end
    end

    // Header fields and decoded length
    always_ff @(posedge clk) begin
        if (rx_fifo_rd_en) begin
            case (state)
                parser_pkg::CMD: begin
                    hdr.cmd <= cmd_in;
                    exp_len <= exp_len_in;
                end
                parser_pkg::ADDR0: hdr.addr[7:0]   <= rx_fifo_data;  // LSB first
                parser_pkg::ADDR1: hdr.addr[15:8]  <= rx_fifo_data;
                parser_pkg::ADDR2: hdr.addr[23:16] <= rx_fifo_data;
                parser_pkg::ADDR3: hdr.addr[31:24] <= rx_fifo_data;
                default: ;
            endcase
        end
        if ((state == parser_pkg::DONE || state == parser_pkg::ERROR) && frame_consumed) begin
            hdr <= '0;
        end
    end

    assign frame_open = (state != parser_pkg::IDLE) && (state != parser_pkg::DONE) &&
                        (state != parser_pkg::ERROR);
    assign busy       = (state != parser_pkg::IDLE);

endmodule

// ==== frame_parser_top.sv ====
`timescale 1ns/1ps

module frame_parser_top #(
    parameter int TIMEOUT_CYCLES = 1000  // Zero disables the stall timeout
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [7:0]                       rx_fifo_data,
    input  logic                             rx_fifo_empty,
    output logic                             rx_fifo_rd_en,
    output parser_pkg::frame_hdr_t           hdr,
    output logic [parser_pkg::PAY_IDX_W-1:0] data_count,
    input  logic [parser_pkg::PAY_IDX_W-1:0] data_rd_idx,
    output logic [7:0]                       data_rd_byte,
    output logic                             frame_valid,
    output logic                             frame_error,
    output logic [7:0]                       error_status,
    input  logic                             frame_consumed,
    output logic                             parser_busy
);

    logic [7:0]                crc;
    logic                      crc_clear;
    logic                      crc_enable;
    logic                      frame_open;
    logic                      timeout;
    logic                      pay_clear;
    logic                      pay_wr;
    parser_pkg::frame_result_t result;

    crc8_calc crc_calc (
        .clk     (clk),
        .rst     (rst),
        .clear   (crc_clear),
        .enable  (crc_enable),
        .data_in (rx_fifo_data),
        .crc     (crc)
    );

    byte_timeout #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) idle_timer (
        .clk        (clk),
        .rst        (rst),
        .frame_open (frame_open),
        .byte_seen  (rx_fifo_rd_en),  // Every pop restarts the gap count
        .timeout    (timeout)
    );

    payload_buffer pay_buf (
        .clk     (clk),
        .rst     (rst),
        .clear   (pay_clear),
        .wr      (pay_wr),
        .wr_byte (rx_fifo_data),
        .count   (data_count),
        .rd_idx  (data_rd_idx),
        .rd_byte (data_rd_byte)
    );

    frame_fsm fsm (
        .clk            (clk),
        .rst            (rst),
        .rx_fifo_data   (rx_fifo_data),
        .rx_fifo_empty  (rx_fifo_empty),
        .rx_fifo_rd_en  (rx_fifo_rd_en),
        .crc            (crc),
        .crc_clear      (crc_clear),
        .crc_enable     (crc_enable),
        .timeout        (timeout),
        .frame_open     (frame_open),
        .pay_count      (data_count),
        .pay_clear      (pay_clear),
        .pay_wr         (pay_wr),
        .frame_consumed (frame_consumed),
        .hdr            (hdr),
        .result         (result),
        .busy           (parser_busy)
    );

    // Result struct out to the consumer ports
    assign frame_valid  = result.valid;
    assign frame_error  = result.error;
    assign error_status = result.status;

endmodule

// ==== frame_parser_props.sv ====
`timescale 1ns/1ps

module frame_parser_props (
    input logic                      clk,
    input logic                      rst,
    input logic                      rx_fifo_empty,
    input logic                      rx_fifo_rd_en,
    input parser_pkg::parser_state_t state,
    input parser_pkg::frame_result_t result
);

    // A finished frame is either good or bad, never both
    result_excl: assert property (@(posedge clk) disable iff (rst)
        !(result.valid && result.error))
        else $error("frame result has valid and error set together");

    no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        rx_fifo_empty |-> !rx_fifo_rd_en)
        else $error("FIFO read enable high while the FIFO is empty");

    // Held result blocks the FIFO
    hold_no_pop: assert property (@(posedge clk) disable iff (rst)
        (state == parser_pkg::DONE || state == parser_pkg::ERROR) |-> !rx_fifo_rd_en)
        else $error("FIFO read while a frame result is held");

endmodule

bind frame_fsm frame_parser_props props (
    .clk           (clk),
    .rst           (rst),
    .rx_fifo_empty (rx_fifo_empty),
    .rx_fifo_rd_en (rx_fifo_rd_en),
    .state         (state),
    .result        (result)
);

// ==== tb_frame_parser.sv ====
`timescale 1ns/1ps

module tb_frame_parser;

    logic                             clk;
    logic                             rst;
    logic [7:0]                       rx_fifo_data;
    logic                             rx_fifo_empty;
    logic                             rx_fifo_rd_en;
    parser_pkg::frame_hdr_t           hdr;
    logic [parser_pkg::PAY_IDX_W-1:0] data_count;
    logic [parser_pkg::PAY_IDX_W-1:0] data_rd_idx;
    logic [7:0]                       data_rd_byte;
    logic                             frame_valid;
    logic                             frame_error;
    logic [7:0]                       error_status;
    logic                             frame_consumed;
    logic                             parser_busy;

    logic [7:0] tx_bytes[$];  // Bytes of the current test
    logic [7:0] fifo_q[$];    // Bytes not yet popped by the DUT
    logic       popped;
    int         gap_left;
    int         seed;
    int         fd;
    string      test_name;
    int         gap_mode;
    int         exp_valid;
    logic [7:0] exp_status;
    logic [7:0] exp_cmd;
    logic [31:0] exp_addr;
    int         exp_count;
    int         checks;
    int         errors;
    int         tests_run;
    bit         hung;
    bit         got_test;

    frame_parser_top #(
        .TIMEOUT_CYCLES (40)
    ) dut (
        .clk            (clk),
        .rst            (rst),
        .rx_fifo_data   (rx_fifo_data),
        .rx_fifo_empty  (rx_fifo_empty),
        .rx_fifo_rd_en  (rx_fifo_rd_en),
        .hdr            (hdr),
        .data_count     (data_count),
        .data_rd_idx    (data_rd_idx),
        .data_rd_byte   (data_rd_byte),
        .frame_valid    (frame_valid),
        .frame_error    (frame_error),
        .error_status   (error_status),
        .frame_consumed (frame_consumed),
        .parser_busy    (parser_busy)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        popped <= rx_fifo_rd_en;  // Pop seen by the DUT at this edge
    end

    // Show-ahead FIFO model, updated on the falling edge
    always @(negedge clk) begin
        if (popped && fifo_q.size() > 0) begin
            void'(fifo_q.pop_front());
            if (gap_mode == 1) begin
                gap_left = $random(seed) & 3;
            end
        end
        if (fifo_q.size() > 0 && gap_left == 0) begin
            rx_fifo_empty = 1'b0;
            rx_fifo_data  = fifo_q[0];
        end else begin
            rx_fifo_empty = 1'b1;
            if (fifo_q.size() > 0) begin
                gap_left--;
            end
        end
    end

    task automatic report_mismatch(input string field, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("Error in %s: %s expected %0h, actual %0h", test_name, field, exp_v, act_v);
        errors++;
    endtask

    // Outputs right after reset, before any byte arrives
    task automatic check_reset_state();
        test_name = "reset";
        checks += 5;
        if (frame_valid !== 1'b0) report_mismatch("frame_valid", 0, frame_valid);
        if (frame_error !== 1'b0) report_mismatch("frame_error", 0, frame_error);
        if (error_status !== 8'h00) report_mismatch("error_status", 0, error_status);
        if (parser_busy !== 1'b0) report_mismatch("parser_busy", 0, parser_busy);
        if (rx_fifo_rd_en !== 1'b0) report_mismatch("rx_fifo_rd_en", 0, rx_fifo_rd_en);
    endtask

    // One test line, comment lines start with #
    task automatic read_test(output bit got);
        string      tok;
        string      rest;
        int         rc;
        int         n_bytes;
        logic [7:0] b;
        got = 0;
        rc = $fscanf(fd, "%s", tok);
        while (rc == 1 && tok[0] == "#") begin
            rc = $fgets(rest, fd);
            rc = $fscanf(fd, "%s", tok);
        end
        if (rc == 1) begin
            test_name = tok;
            rc = $fscanf(fd, "%d", n_bytes);
            tx_bytes.delete();
            for (int i = 0; i < n_bytes; i++) begin
                rc = $fscanf(fd, "%h", b);
                tx_bytes.push_back(b);
            end
            rc = $fscanf(fd, "%d %d %h %h %h %d", gap_mode, exp_valid, exp_status,
                         exp_cmd, exp_addr, exp_count);
            got = (rc == 6);
            if (!got) begin
                $display("Test line for %s in frame_tests.txt is incomplete", test_name);
                errors++;
            end
        end
    endtask

    task automatic run_test();
        int cycles;
        int sof_idx;
        @(posedge clk);
        gap_left = (gap_mode == 1) ? ($random(seed) & 3) : 0;
        foreach (tx_bytes[i]) begin
            fifo_q.push_back(tx_bytes[i]);
        end
        cycles = 0;
        @(negedge clk);
        while (!(frame_valid || frame_error) && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        if (!(frame_valid || frame_error)) begin
            $display("No frame result within 2000 cycles in test %s", test_name);
            errors++;
            hung = 1;
        end else begin
            checks += 6;
            if (frame_valid !== exp_valid[0]) begin
                report_mismatch("frame_valid", exp_valid, frame_valid);
            end
            if (frame_error !== !exp_valid[0]) begin
                report_mismatch("frame_error", !exp_valid[0], frame_error);
            end
            if (error_status !== exp_status) report_mismatch("error_status", exp_status, error_status);
            if (hdr[39:32] !== exp_cmd) report_mismatch("cmd", exp_cmd, hdr[39:32]);
            if (hdr.addr !== exp_addr) report_mismatch("addr", exp_addr, hdr.addr);
            if (parser_busy !== 1'b1) report_mismatch("parser_busy", 1, parser_busy);
            checks++;
            if (data_count !== exp_count[5:0]) report_mismatch("data_count", exp_count, data_count);
            if (exp_valid != 0) begin
                sof_idx = 0;
                for (int i = tx_bytes.size() - 1; i >= 0; i--) begin
                    if (tx_bytes[i] == bridge_proto_pkg::SOF_H2D) sof_idx = i;  // First start byte
                end
                for (int i = 0; i < exp_count; i++) begin
                    @(negedge clk);
                    data_rd_idx = i;
                    #1;
                    checks++;
                    if (data_rd_byte !== tx_bytes[sof_idx + 6 + i]) begin
                        report_mismatch($sformatf("payload[%0d]", i), tx_bytes[sof_idx + 6 + i],
                                        data_rd_byte);
                    end
                end
            end
            @(negedge clk);
            frame_consumed = 1'b1;
            @(negedge clk);
            frame_consumed = 1'b0;
            checks++;
            if (frame_valid || frame_error || data_count != 0 || parser_busy) begin
                $display("Result was not released after frame_consumed in test %s", test_name);
                errors++;
            end
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        rx_fifo_data   = 8'h00;
        rx_fifo_empty  = 1'b1;
        data_rd_idx    = '0;
        frame_consumed = 1'b0;
        popped         = 1'b0;
        gap_left       = 0;
        gap_mode       = 0;
        seed           = 32'h8ce5;
        checks         = 0;
        errors         = 0;
        tests_run      = 0;
        hung           = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        check_reset_state();

        fd = $fopen("frame_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file frame_tests.txt");
            errors++;
        end else begin
            read_test(got_test);
            while (got_test && !hung) begin
                run_test();
                tests_run++;
                if (!hung) read_test(got_test);
            end
            $fclose(fd);
            if (tests_run == 0) begin
                $display("No tests were read from frame_tests.txt");
                errors++;
            end
        end

        $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== frame_tests.txt ====
# name nbytes stream_bytes(hex) gap_mode exp_valid exp_status(hex) exp_cmd(hex) exp_addr(hex) exp_count
# gap_mode 0 no gaps, 1 random gaps of 0..3 cycles, 2 stream stops after the listed bytes
t1_write_word 15 A5 21 10 00 00 00 01 02 03 04 05 06 07 08 9F 0 1 00 21 00000010 8
t2_read 7 A5 A0 04 00 00 00 AB 0 1 00 A0 00000004 0
t3_bad_crc 7 A5 A0 04 00 00 00 AC 0 0 01 A0 00000004 0
t4_bad_size 7 A5 32 08 00 00 00 00 0 0 02 32 00000008 0
t5_junk_gaps 14 00 FF 5A A5 03 20 00 00 00 11 22 33 44 1C 1 1 00 03 00000020 4
t5_next_frame 15 A5 21 10 00 00 00 01 02 03 04 05 06 07 08 9F 1 1 00 21 00000010 8
t6_stall 6 A5 21 40 00 00 00 2 0 04 21 00000040 0
t6_after_stall 7 A5 A0 04 00 00 00 AB 0 1 00 A0 00000004 0

// ==== all.f ====
bridge_proto_pkg.sv
parser_pkg.sv
crc8_calc.sv
byte_timeout.sv
payload_buffer.sv
frame_fsm.sv
frame_parser_top.sv
frame_parser_props.sv
tb_frame_parser.sv
